// ==== logic/exec_pkg.sv ====
// Shared widths, operation codes and constants for the execute stage
// RV32 only; the operation code is 5 bits wide and its encoding is full
`default_nettype none

package exec_pkg;

    localparam int unsigned XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [3:0]      byte_en_t;

    // Decoded operations seen by the stage
    typedef enum logic [4:0] {
        NOP,
        ADD, SUB, SLT, SLTU,
        XOR, OR, AND,
        SLL, SRL, SRA,
        LUI,
        LB, LBU, LH, LHU, LW,
        SB, SH, SW,
        BEQ, BNE, BLT, BLTU, BGE, BGEU,
        JAL, JALR,
        DIV, DIVU, REM, REMU
    } exec_op_e;

    // Shift amount taken from the low bits of op_b
    localparam int unsigned SHAMT_W = 5;

    // Divider runs one quotient bit per step
    localparam int unsigned DIV_STEPS = 32;
    localparam int unsigned DIV_CNT_W = 5;

    // Return address increments
    localparam int unsigned INSN_BYTES  = 4;
    localparam int unsigned CINSN_BYTES = 2;

endpackage

`default_nettype wire

// ==== logic/exec_op_if.sv ====
// Operand bundle from the top level, plus the divider control handshake
// Top level drives every field of exec_op_if
`default_nettype none

interface exec_op_if;
    exec_pkg::exec_op_e op;
    exec_pkg::word_t    op_a;
    exec_pkg::word_t    op_b;
    exec_pkg::word_t    op_c;
    exec_pkg::word_t    pc;
    logic               compressed;

    modport alu_mp (input op, input op_a, input op_b, input op_c, input pc, input compressed);
    modport mem_mp (input op, input op_a, input op_b, input op_c);
    modport div_mp (input op, input op_a, input op_b);
    modport res_mp (input op, input op_b);
endinterface

// load captures operands, step runs one iteration, finish marks a valid result
interface div_ctrl_if;
    logic load;
    logic step;
    logic finish;
    logic busy;

    modport ctrl_mp (output load, output step, output finish, output busy);
    modport dp_mp (input load, input step, input finish);
endinterface

`default_nettype wire

// ==== logic/exec_alu.sv ====
// Integer ALU with branch decision and jump target
// All outputs are combinational on the operand bundle
`default_nettype none

module exec_alu (
    exec_op_if.alu_mp       ops,
    output exec_pkg::word_t alu_result_o,
    output exec_pkg::word_t link_addr_o,
    output exec_pkg::word_t jump_target_o,
    output logic            jump_o
);

    exec_pkg::word_t                   sum;
    exec_pkg::word_t                   diff;
    exec_pkg::word_t                   branch_target;
    logic [exec_pkg::SHAMT_W-1:0]      shamt;
    logic                              equal;
    logic                              less_than;
    logic                              less_than_u;

    ////////////////////////////////////////
    // Arithmetic and compare
    ////////////////////////////////////////

    assign shamt       = ops.op_b[exec_pkg::SHAMT_W-1:0];
    assign sum         = ops.op_a + ops.op_b;
    assign diff        = ops.op_a - ops.op_b;
    assign equal       = (ops.op_a == ops.op_b);
    assign less_than   = ($signed(ops.op_a) < $signed(ops.op_b));
    assign less_than_u = (ops.op_a < ops.op_b);

    always_comb begin
        case (ops.op)
            exec_pkg::SUB:  alu_result_o = diff;
            exec_pkg::SLT:  alu_result_o = exec_pkg::word_t'(less_than);
            exec_pkg::SLTU: alu_result_o = exec_pkg::word_t'(less_than_u);
            exec_pkg::XOR:  alu_result_o = ops.op_a ^ ops.op_b;
            exec_pkg::OR:   alu_result_o = ops.op_a | ops.op_b;
            exec_pkg::AND:  alu_result_o = ops.op_a & ops.op_b;
            exec_pkg::SLL:  alu_result_o = ops.op_a << shamt;
            exec_pkg::SRL:  alu_result_o = ops.op_a >> shamt;
            exec_pkg::SRA:  alu_result_o = exec_pkg::word_t'($signed(ops.op_a) >>> shamt);
            // ADD and anything without its own result
            default:        alu_result_o = sum;
        endcase
    end

    ////////////////////////////////////////
    // Branch and jump
    ////////////////////////////////////////

    assign branch_target = ops.pc + ops.op_c;

    assign link_addr_o = ops.compressed ? ops.pc + exec_pkg::word_t'(exec_pkg::CINSN_BYTES)
                                        : ops.pc + exec_pkg::word_t'(exec_pkg::INSN_BYTES);

    always_comb begin
        case (ops.op)
            exec_pkg::JAL:  jump_target_o = sum;
            // Bit 0 of a register target is dropped
            exec_pkg::JALR: jump_target_o = {sum[exec_pkg::XLEN-1:1], 1'b0};
            default:        jump_target_o = branch_target;
        endcase
    end

    always_comb begin
        case (ops.op)
            exec_pkg::BEQ:  jump_o = equal;
            exec_pkg::BNE:  jump_o = !equal;
            exec_pkg::BLT:  jump_o = less_than;
            exec_pkg::BLTU: jump_o = less_than_u;
            exec_pkg::BGE:  jump_o = !less_than;
            exec_pkg::BGEU: jump_o = !less_than_u;
            exec_pkg::JAL,
            exec_pkg::JALR: jump_o = 1'b1;
            default:        jump_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/exec_mem_access.sv ====
// Load and store request generation, word aligned address only
// Store data is replicated so any byte lane can take it
`default_nettype none

module exec_mem_access (
    exec_op_if.mem_mp        ops,
    output exec_pkg::word_t  mem_address_o,
    output logic             mem_read_enable_o,
    output exec_pkg::byte_en_t mem_write_enable_o,
    output exec_pkg::word_t  mem_write_data_o
);

    exec_pkg::word_t eff_addr;

    assign eff_addr          = ops.op_a + ops.op_b;
    assign mem_address_o     = {eff_addr[exec_pkg::XLEN-1:2], 2'b00};
    assign mem_read_enable_o = ops.op inside {exec_pkg::LB, exec_pkg::LBU, exec_pkg::LH,
                                              exec_pkg::LHU, exec_pkg::LW};

    // Lane select from the low address bits
    always_comb begin
        case (ops.op)
            exec_pkg::SB:  mem_write_enable_o = exec_pkg::byte_en_t'(4'b0001 << eff_addr[1:0]);
            exec_pkg::SH:  mem_write_enable_o = eff_addr[1] ? 4'b1100 : 4'b0011;
            exec_pkg::SW:  mem_write_enable_o = 4'b1111;
            default:       mem_write_enable_o = 4'b0000;
        endcase
    end

    always_comb begin
        case (ops.op)
            exec_pkg::SB:  mem_write_data_o = {4{ops.op_c[7:0]}};
            exec_pkg::SH:  mem_write_data_o = {2{ops.op_c[15:0]}};
            default:       mem_write_data_o = ops.op_c;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/div_control.sv ====
// Divider sequencing: operands load in the first cycle, then DIV_STEPS steps
// Done waits for stall_i to drop before the unit goes idle again
`default_nettype none

module div_control (
    input  logic           clk,
    input  logic           reset_n,
    exec_op_if.div_mp      ops,
    input  logic           stall_i,
    div_ctrl_if.ctrl_mp    ctl,
    output logic           hold_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ITER,
        S_DONE
    } div_state_e;

    div_state_e                      state;
    logic [exec_pkg::DIV_CNT_W-1:0]  step_cnt;
    logic                            is_div;

    assign is_div = ops.op inside {exec_pkg::DIV, exec_pkg::DIVU,
                                   exec_pkg::REM, exec_pkg::REMU};

    // Load happens in the idle cycle the divide first shows up
    assign ctl.load   = (state == S_IDLE) && is_div;
    assign ctl.step   = (state == S_ITER);
    assign ctl.finish = (state == S_DONE);
    assign ctl.busy   = ctl.load || ctl.step;
    assign hold_o     = ctl.busy;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= S_IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    step_cnt <= '0;
                    if (is_div)
                        state <= S_ITER;
                end
                S_ITER: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (int'(step_cnt) == exec_pkg::DIV_STEPS - 1)
                        state <= S_DONE;
                end
                default: begin
                    if (!stall_i)
                        state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/div_datapath.sv ====
// Restoring divider on magnitudes, signs fixed up at the end
// Result is valid only while finish is high, otherwise zero
`default_nettype none

module div_datapath (
    input  logic            clk,
    input  logic            reset_n,
    exec_op_if.div_mp       ops,
    div_ctrl_if.dp_mp       ctl,
    output exec_pkg::word_t div_result_o
);

    localparam exec_pkg::word_t MOST_NEG = {1'b1, {(exec_pkg::XLEN-1){1'b0}}};

    logic                      is_signed;
    exec_pkg::word_t           abs_a;
    exec_pkg::word_t           abs_b;
    exec_pkg::word_t           dividend;
    exec_pkg::word_t           divisor;
    exec_pkg::word_t           quot;
    exec_pkg::word_t           rem;
    logic [exec_pkg::XLEN:0]   rem_shift;
    logic [exec_pkg::XLEN:0]   trial;
    logic                      neg_q;
    logic                      neg_r;
    logic                      div_zero;
    logic                      div_ovf;
    exec_pkg::word_t           quot_final;
    exec_pkg::word_t           rem_final;

    assign is_signed = ops.op inside {exec_pkg::DIV, exec_pkg::REM};
    assign abs_a     = (is_signed && ops.op_a[exec_pkg::XLEN-1]) ? -ops.op_a : ops.op_a;
    assign abs_b     = (is_signed && ops.op_b[exec_pkg::XLEN-1]) ? -ops.op_b : ops.op_b;

    // One restoring step: shift in the next dividend bit and try to subtract
    assign rem_shift = {rem, quot[exec_pkg::XLEN-1]};
    assign trial     = rem_shift - {1'b0, divisor};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            neg_q    <= 1'b0;
            neg_r    <= 1'b0;
            div_zero <= 1'b0;
            div_ovf  <= 1'b0;
        end else if (ctl.load) begin
            neg_q    <= is_signed && (ops.op_a[exec_pkg::XLEN-1] ^ ops.op_b[exec_pkg::XLEN-1]);
            neg_r    <= is_signed && ops.op_a[exec_pkg::XLEN-1];
            div_zero <= (ops.op_b == '0);
            div_ovf  <= is_signed && (ops.op_a == MOST_NEG) && (ops.op_b == '1);
        end
    end

    always_ff @(posedge clk) begin
        if (ctl.load) begin
            dividend <= ops.op_a;
            divisor  <= abs_b;
            quot     <= abs_a;
            rem      <= '0;
        end else if (ctl.step) begin
            if (!trial[exec_pkg::XLEN]) begin
                rem  <= trial[exec_pkg::XLEN-1:0];
                quot <= {quot[exec_pkg::XLEN-2:0], 1'b1};
            end else begin
                rem  <= rem_shift[exec_pkg::XLEN-1:0];
                quot <= {quot[exec_pkg::XLEN-2:0], 1'b0};
            end
        end
    end

    ////////////////////////////////////////
    // Sign fix-up and special cases
    ////////////////////////////////////////

    always_comb begin
        if (div_zero) begin
            quot_final = '1;
            rem_final  = dividend;
        end else if (div_ovf) begin
            quot_final = dividend;
            rem_final  = '0;
        end else begin
            quot_final = neg_q ? -quot : quot;
            rem_final  = neg_r ? -rem : rem;
        end
    end

    // Op is still presented upstream in the finish cycle
    always_comb begin
        if (!ctl.finish)
            div_result_o = '0;
        else if (ops.op inside {exec_pkg::DIV, exec_pkg::DIVU})
            div_result_o = quot_final;
        else
            div_result_o = rem_final;
    end

endmodule

`default_nettype wire

// ==== logic/exec_result_reg.sv ====
// Result select and the stage output register
// A stall or hold cycle loads a bubble instead of the instruction
`default_nettype none

module exec_result_reg (
    input  logic                clk,
    input  logic                reset_n,
    exec_op_if.res_mp           ops,
    input  exec_pkg::reg_idx_t  rd_i,
    input  logic                stall_i,
    input  logic                hold_i,
    input  exec_pkg::word_t     alu_result_i,
    input  exec_pkg::word_t     link_addr_i,
    input  exec_pkg::word_t     div_result_i,
    output logic                write_enable_o,
    output exec_pkg::exec_op_e  op_o,
    output exec_pkg::word_t     result_o,
    output exec_pkg::reg_idx_t  rd_o
);

    exec_pkg::word_t result;
    logic            write_enable;

    always_comb begin
        case (ops.op)
            exec_pkg::JAL,
            exec_pkg::JALR:  result = link_addr_i;
            exec_pkg::LUI:   result = ops.op_b;
            exec_pkg::DIV,
            exec_pkg::DIVU,
            exec_pkg::REM,
            exec_pkg::REMU:  result = div_result_i;
            default:         result = alu_result_i;
        endcase
    end

    // No register write for bubbles, stores and conditional branches
    assign write_enable = !(ops.op inside {exec_pkg::NOP,
                                           exec_pkg::SB, exec_pkg::SH, exec_pkg::SW,
                                           exec_pkg::BEQ, exec_pkg::BNE,
                                           exec_pkg::BLT, exec_pkg::BLTU,
                                           exec_pkg::BGE, exec_pkg::BGEU});

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            write_enable_o <= 1'b0;
            op_o           <= exec_pkg::NOP;
            result_o       <= '0;
            rd_o           <= '0;
        end else if (!stall_i && !hold_i) begin
            write_enable_o <= write_enable;
            op_o           <= ops.op;
            result_o       <= result;
            rd_o           <= rd_i;
        end else begin
            write_enable_o <= 1'b0;
            op_o           <= exec_pkg::NOP;
            result_o       <= '0;
            rd_o           <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/exec_stage.sv ====
// Execute stage top: ALU, memory request, divider and result register
// Upstream must keep the instruction stable while hold_o is high
`default_nettype none

module exec_stage (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                stall_i,
    input  exec_pkg::exec_op_e  op_i,
    input  exec_pkg::word_t     op_a_i,
    input  exec_pkg::word_t     op_b_i,
    input  exec_pkg::word_t     op_c_i,
    input  exec_pkg::word_t     pc_i,
    input  logic                compressed_i,
    input  exec_pkg::reg_idx_t  rd_i,
    output logic                hold_o,
    output logic                jump_o,
    output exec_pkg::word_t     jump_target_o,
    output exec_pkg::word_t     mem_address_o,
    output logic                mem_read_enable_o,
    output exec_pkg::byte_en_t  mem_write_enable_o,
    output exec_pkg::word_t     mem_write_data_o,
    output logic                write_enable_o,
    output exec_pkg::exec_op_e  op_o,
    output exec_pkg::word_t     result_o,
    output exec_pkg::reg_idx_t  rd_o
);

    exec_pkg::word_t alu_result;
    exec_pkg::word_t link_addr;
    exec_pkg::word_t div_result;

    exec_op_if  u_ops ();
    div_ctrl_if u_div_ctl ();

    assign u_ops.op         = op_i;
    assign u_ops.op_a       = op_a_i;
    assign u_ops.op_b       = op_b_i;
    assign u_ops.op_c       = op_c_i;
    assign u_ops.pc         = pc_i;
    assign u_ops.compressed = compressed_i;

    exec_alu u_alu (
        .ops           (u_ops.alu_mp),
        .alu_result_o  (alu_result),
        .link_addr_o   (link_addr),
        .jump_target_o (jump_target_o),
        .jump_o        (jump_o)
    );

    exec_mem_access u_mem_access (
        .ops                (u_ops.mem_mp),
        .mem_address_o      (mem_address_o),
        .mem_read_enable_o  (mem_read_enable_o),
        .mem_write_enable_o (mem_write_enable_o),
        .mem_write_data_o   (mem_write_data_o)
    );

    ////////////////////////////////////////
    // Divider
    ////////////////////////////////////////

    div_control u_div_control (
        .clk     (clk),
        .reset_n (reset_n),
        .ops     (u_ops.div_mp),
        .stall_i (stall_i),
        .ctl     (u_div_ctl.ctrl_mp),
        .hold_o  (hold_o)
    );

    div_datapath u_div_datapath (
        .clk          (clk),
        .reset_n      (reset_n),
        .ops          (u_ops.div_mp),
        .ctl          (u_div_ctl.dp_mp),
        .div_result_o (div_result)
    );

    exec_result_reg u_result_reg (
        .clk            (clk),
        .reset_n        (reset_n),
        .ops            (u_ops.res_mp),
        .rd_i           (rd_i),
        .stall_i        (stall_i),
        .hold_i         (hold_o),
        .alu_result_i   (alu_result),
        .link_addr_i    (link_addr),
        .div_result_i   (div_result),
        .write_enable_o (write_enable_o),
        .op_o           (op_o),
        .result_o       (result_o),
        .rd_o           (rd_o)
    );

endmodule

`default_nettype wire

// ==== tests/exec_checks.svh ====
// Compare tasks for the execute stage testbench, included inside its top module
// Every task stops the run at the first mismatch
`ifndef EXEC_CHECKS_SVH
`define EXEC_CHECKS_SVH

task automatic fail_and_stop();
    $display("Test failed");
    $fatal(1, "Stopped at the first mismatch");
endtask

task automatic check_word(input string field, input exec_pkg::word_t actual,
                          input exec_pkg::word_t expected);
    if (actual !== expected) begin
        $display("Error: time %0t: %s is %h, expected %h", $time, field, actual, expected);
        fail_and_stop();
    end
endtask

task automatic check_op(input string field, input exec_pkg::exec_op_e actual,
                        input exec_pkg::exec_op_e expected);
    if (actual !== expected) begin
        $display("Error: time %0t: %s is %s, expected %s", $time, field,
                 actual.name(), expected.name());
        fail_and_stop();
    end
endtask

task automatic check_strobe(input string field, input exec_pkg::byte_en_t actual,
                            input exec_pkg::byte_en_t expected);
    if (actual !== expected) begin
        $display("Error: time %0t: %s is %b, expected %b", $time, field, actual, expected);
        fail_and_stop();
    end
endtask

task automatic check_bit(input string field, input logic actual, input logic expected);
    if (actual !== expected) begin
        $display("Error: time %0t: %s is %b, expected %b", $time, field, actual, expected);
        fail_and_stop();
    end
endtask

`endif

// ==== tests/exec_stage_tb.sv ====
// Directed test of the execute stage driven from tests/exec_tests.txt
// Run from the project root so the vector file path resolves
`default_nettype none

module exec_stage_tb;

    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 16;
    localparam int CYCLES_PER_VEC = 40;

    // One line of the vector file
    typedef struct packed {
        exec_pkg::exec_op_e op;
        exec_pkg::word_t    op_a;
        exec_pkg::word_t    op_b;
        exec_pkg::word_t    op_c;
        exec_pkg::word_t    pc;
        logic               compressed;
        exec_pkg::reg_idx_t rd;
        logic               stall;
        exec_pkg::word_t    exp_result;
        logic               exp_we;
        logic               exp_jump;
        exec_pkg::word_t    exp_target;
        exec_pkg::word_t    exp_addr;
        logic               exp_re;
        exec_pkg::byte_en_t exp_strobe;
        exec_pkg::word_t    exp_wdata;
    } vector_t;

    logic               clk;
    logic               reset_n;
    logic               stall_i;
    exec_pkg::exec_op_e op_i;
    exec_pkg::word_t    op_a_i;
    exec_pkg::word_t    op_b_i;
    exec_pkg::word_t    op_c_i;
    exec_pkg::word_t    pc_i;
    logic               compressed_i;
    exec_pkg::reg_idx_t rd_i;
    logic               hold_o;
    logic               jump_o;
    exec_pkg::word_t    jump_target_o;
    exec_pkg::word_t    mem_address_o;
    logic               mem_read_enable_o;
    exec_pkg::byte_en_t mem_write_enable_o;
    exec_pkg::word_t    mem_write_data_o;
    logic               write_enable_o;
    exec_pkg::exec_op_e op_o;
    exec_pkg::word_t    result_o;
    exec_pkg::reg_idx_t rd_o;

    vector_t vectors[$];
    bit      vectors_ready;
    int      vec_idx;

    `include "exec_checks.svh"

    exec_stage u_exec_stage (
        .clk                (clk),
        .reset_n            (reset_n),
        .stall_i            (stall_i),
        .op_i               (op_i),
        .op_a_i             (op_a_i),
        .op_b_i             (op_b_i),
        .op_c_i             (op_c_i),
        .pc_i               (pc_i),
        .compressed_i       (compressed_i),
        .rd_i               (rd_i),
        .hold_o             (hold_o),
        .jump_o             (jump_o),
        .jump_target_o      (jump_target_o),
        .mem_address_o      (mem_address_o),
        .mem_read_enable_o  (mem_read_enable_o),
        .mem_write_enable_o (mem_write_enable_o),
        .mem_write_data_o   (mem_write_data_o),
        .write_enable_o     (write_enable_o),
        .op_o               (op_o),
        .result_o           (result_o),
        .rd_o               (rd_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic string field_tag(input string sig);
        return $sformatf("vector %0d %s", vec_idx, sig);
    endfunction

    function automatic logic is_divide(input exec_pkg::exec_op_e op);
        return op inside {exec_pkg::DIV, exec_pkg::DIVU, exec_pkg::REM, exec_pkg::REMU};
    endfunction

    ////////////////////////////////////////
    // Vector file
    ////////////////////////////////////////

    task automatic load_vectors();
        int               fd;
        int               n_chars;
        int               n_fields;
        logic [8*256-1:0] text_line;
        logic [31:0]      fld [16];
        vector_t          v;
        fd = $fopen("tests/exec_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file tests/exec_tests.txt");
            $display("Test failed");
            $fatal(1, "Missing vector file");
        end else begin
            while (!$feof(fd)) begin
                text_line = '0;
                n_chars = $fgets(text_line, fd);
                if (n_chars > 0) begin
                    // Comment and blank lines do not scan as 16 fields
                    n_fields = $sscanf(text_line,
                        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                        fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14], fld[15]);
                    if (n_fields == 16) begin
                        v.op         = exec_pkg::exec_op_e'(fld[0][4:0]);
                        v.op_a       = fld[1];
                        v.op_b       = fld[2];
                        v.op_c       = fld[3];
                        v.pc         = fld[4];
                        v.compressed = fld[5][0];
                        v.rd         = fld[6][4:0];
                        v.stall      = fld[7][0];
                        v.exp_result = fld[8];
                        v.exp_we     = fld[9][0];
                        v.exp_jump   = fld[10][0];
                        v.exp_target = fld[11];
                        v.exp_addr   = fld[12];
                        v.exp_re     = fld[13][0];
                        v.exp_strobe = fld[14][3:0];
                        v.exp_wdata  = fld[15];
                        vectors.push_back(v);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_vector(input vector_t v);
        op_i         = v.op;
        op_a_i       = v.op_a;
        op_b_i       = v.op_b;
        op_c_i       = v.op_c;
        pc_i         = v.pc;
        compressed_i = v.compressed;
        rd_i         = v.rd;
        stall_i      = v.stall;
    endtask

    // Outputs that follow the inputs in the same cycle
    task automatic check_comb_outputs(input vector_t v);
        check_bit(field_tag("jump_o"), jump_o, v.exp_jump);
        if (v.exp_jump)
            check_word(field_tag("jump_target_o"), jump_target_o, v.exp_target);
        check_bit(field_tag("mem_read_enable_o"), mem_read_enable_o, v.exp_re);
        check_strobe(field_tag("mem_write_enable_o"), mem_write_enable_o, v.exp_strobe);
        if (v.exp_re || v.exp_strobe != '0)
            check_word(field_tag("mem_address_o"), mem_address_o, v.exp_addr);
        if (v.exp_strobe != '0)
            check_word(field_tag("mem_write_data_o"), mem_write_data_o, v.exp_wdata);
    endtask

    task automatic count_hold_cycles(output int cycles);
        cycles = 0;
        while (hold_o === 1'b1) begin
            cycles++;
            @(negedge clk);
        end
    endtask

    // A stalled line must leave a bubble behind
    task automatic check_registered_outputs(input vector_t v);
        exec_pkg::exec_op_e exp_op;
        exec_pkg::reg_idx_t exp_rd;
        exp_op = v.stall ? exec_pkg::NOP : v.op;
        exp_rd = v.stall ? '0 : v.rd;
        check_op(field_tag("op_o"), op_o, exp_op);
        check_bit(field_tag("write_enable_o"), write_enable_o, v.exp_we);
        check_word(field_tag("rd_o"), exec_pkg::word_t'(rd_o), exec_pkg::word_t'(exp_rd));
        if (v.exp_we || v.stall)
            check_word(field_tag("result_o"), result_o, v.exp_result);
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        int hold_cycles;
        reset_n       = 1'b0;
        stall_i       = 1'b0;
        op_i          = exec_pkg::NOP;
        op_a_i        = '0;
        op_b_i        = '0;
        op_c_i        = '0;
        pc_i          = '0;
        compressed_i  = 1'b0;
        rd_i          = '0;
        vectors_ready = 1'b0;
        vec_idx       = 0;
        load_vectors();
        if (vectors.size() == 0) begin
            $display("The vector file tests/exec_tests.txt holds no vectors");
            $display("Test failed");
            $fatal(1, "Empty vector file");
        end else begin
            vectors_ready = 1'b1;
            repeat (RESET_CYCLES) @(posedge clk);
            #2 reset_n = 1'b1;
            @(posedge clk);
            #1;
            check_op("op_o after reset", op_o, exec_pkg::NOP);
            check_bit("write_enable_o after reset", write_enable_o, 1'b0);
            check_bit("hold_o after reset", hold_o, 1'b0);
            check_bit("jump_o after reset", jump_o, 1'b0);
            check_bit("mem_read_enable_o after reset", mem_read_enable_o, 1'b0);
            check_strobe("mem_write_enable_o after reset", mem_write_enable_o, 4'b0000);
            #1;
            for (int i = 0; i < vectors.size(); i++) begin
                vec_idx = i;
                apply_vector(vectors[i]);
                @(negedge clk);
                check_comb_outputs(vectors[i]);
                if (is_divide(vectors[i].op)) begin
                    // One load cycle plus one cycle per quotient bit
                    count_hold_cycles(hold_cycles);
                    check_word(field_tag("hold_o cycles"), exec_pkg::word_t'(hold_cycles),
                               exec_pkg::word_t'(exec_pkg::DIV_STEPS + 1));
                end else begin
                    check_bit(field_tag("hold_o"), hold_o, 1'b0);
                end
                @(posedge clk);
                #1;
                check_registered_outputs(vectors[i]);
                #1;
            end
            apply_vector('0);
            @(posedge clk);
            $display("Test completed successfully");
            $finish;
        end
    end

    // Watchdog sized from the number of vectors
    initial begin
        wait (vectors_ready);
        #((RESET_CYCLES + 4 + CYCLES_PER_VEC * vectors.size()) * CLK_PERIOD);
        $display("Timeout: the vectors did not complete within the time limit");
        $display("Test failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

// ==== tests/exec_tests.txt ====
# hex: op op_a op_b op_c pc compressed rd stall, then result we jump target address re strobe wdata
# result checked if we or stall is set, target if jump, address for loads and stores, wdata for stores
01 00000005 00000003 00000000 00000000 0 01 0 00000008 1 0 00000000 00000000 0 0 00000000
02 00000005 00000007 00000000 00000000 0 02 0 fffffffe 1 0 00000000 00000000 0 0 00000000
03 ffffffff 00000001 00000000 00000000 0 03 0 00000001 1 0 00000000 00000000 0 0 00000000
04 ffffffff 00000001 00000000 00000000 0 04 0 00000000 1 0 00000000 00000000 0 0 00000000
05 0000ff00 00ff0ff0 00000000 00000000 0 05 0 00fff0f0 1 0 00000000 00000000 0 0 00000000
07 0000ff0f 000f0ff0 00000000 00000000 0 06 0 00000f00 1 0 00000000 00000000 0 0 00000000
08 00000003 00000024 00000000 00000000 0 07 0 00000030 1 0 00000000 00000000 0 0 00000000
09 80000000 0000001f 00000000 00000000 0 08 0 00000001 1 0 00000000 00000000 0 0 00000000
0a 80000000 00000004 00000000 00000000 0 09 0 f8000000 1 0 00000000 00000000 0 0 00000000
0b 00000000 12345000 00000000 00000000 0 0a 0 12345000 1 0 00000000 00000000 0 0 00000000
14 00000005 00000005 00000010 00001000 0 00 0 00000000 0 1 00001010 00000000 0 0 00000000
15 00000005 00000005 00000010 00001000 0 00 0 00000000 0 0 00000000 00000000 0 0 00000000
16 ffffffff 00000001 00000010 00001000 0 00 0 00000000 0 1 00001010 00000000 0 0 00000000
17 ffffffff 00000001 00000010 00001000 0 00 0 00000000 0 0 00000000 00000000 0 0 00000000
18 00000001 ffffffff 00000010 00001000 0 00 0 00000000 0 1 00001010 00000000 0 0 00000000
19 00000001 ffffffff 00000010 00001000 0 00 0 00000000 0 0 00000000 00000000 0 0 00000000
1a 00002000 00000100 00000000 00002000 0 01 0 00002004 1 1 00002100 00000000 0 0 00000000
1a 00002000 00000100 00000000 00002000 1 01 0 00002002 1 1 00002100 00000000 0 0 00000000
1b 00003001 00000004 00000000 00001ffc 0 01 0 00002000 1 1 00003004 00000000 0 0 00000000
0c 00001003 00000002 00000000 00000000 0 0b 0 00001005 1 0 00000000 00001004 1 0 00000000
10 00000ffc 00000008 00000000 00000000 0 0b 0 00001004 1 0 00000000 00001004 1 0 00000000
11 00000100 00000001 000000a5 00000000 0 00 0 00000000 0 0 00000000 00000100 0 2 a5a5a5a5
12 00000200 00000002 1234beef 00000000 0 00 0 00000000 0 0 00000000 00000200 0 c beefbeef
12 00000200 00000000 1234beef 00000000 0 00 0 00000000 0 0 00000000 00000200 0 3 beefbeef
13 00000300 00000005 deadbeef 00000000 0 00 0 00000000 0 0 00000000 00000304 0 f deadbeef
1c 00000014 00000003 00000000 00000000 0 0c 0 00000006 1 0 00000000 00000000 0 0 00000000
1c fffffff0 00000003 00000000 00000000 0 0c 0 fffffffb 1 0 00000000 00000000 0 0 00000000
1e fffffff0 00000003 00000000 00000000 0 0c 0 ffffffff 1 0 00000000 00000000 0 0 00000000
1e 00000014 fffffffd 00000000 00000000 0 0c 0 00000002 1 0 00000000 00000000 0 0 00000000
1d ffffffff 00000010 00000000 00000000 0 0c 0 0fffffff 1 0 00000000 00000000 0 0 00000000
1c 00000005 00000000 00000000 00000000 0 0c 0 ffffffff 1 0 00000000 00000000 0 0 00000000
1f 12345678 00000000 00000000 00000000 0 0c 0 12345678 1 0 00000000 00000000 0 0 00000000
1c 80000000 ffffffff 00000000 00000000 0 0c 0 80000000 1 0 00000000 00000000 0 0 00000000
1e 80000000 ffffffff 00000000 00000000 0 0c 0 00000000 1 0 00000000 00000000 0 0 00000000
01 00000001 00000002 00000000 00000000 0 03 1 00000000 0 0 00000000 00000000 0 0 00000000
10 00000010 00000004 00000000 00000000 0 04 1 00000000 0 0 00000000 00000014 1 0 00000000

// ==== exec_stage.f ====
+incdir+tests
logic/exec_pkg.sv
logic/exec_op_if.sv
logic/exec_alu.sv
logic/exec_mem_access.sv
logic/div_control.sv
logic/div_datapath.sv
logic/exec_result_reg.sv
logic/exec_stage.sv
tests/exec_stage_tb.sv
